//--- include/exerciser_cfg.svh
`ifndef EXERCISER_CFG_SVH
`define EXERCISER_CFG_SVH

// Host memory is addressed in whole lines
`define EX_ADDR_W 32

// Width of the per-run line count
`define EX_COUNT_W 16

// The read engine never has more than this many reads in flight
`define EX_RD_MAX_OUTSTANDING 4

// Length of one frequency measurement in pclk cycles
`define EX_FREQ_WINDOW 256

// Two halves of the 128-bit test identifier
`define EX_TEST_ID_LO 64'h6d2e_41c9_b07a_35f1
`define EX_TEST_ID_HI 64'h3f8a_02d4_e915_7bc6

// Register map size and the address width needed to reach every word
`define EX_NUM_CSRS 16
`define EX_CSR_ADDR_W 4

// Engines reported in the config word
`define EX_NUM_ENGINES 3

`endif

//--- source/exerciser_pkg.sv
`include "exerciser_cfg.svh"

package exerciser_pkg;

    // Command handed from the register block to one engine
    typedef struct packed {
        logic [`EX_ADDR_W-1:0]  base_addr;
        logic [`EX_COUNT_W-1:0] num_lines;
        // Only the write engine looks at the pattern
        logic [63:0]            pattern;
    } eng_cmd_t;

    // Done stays set until the next start of the same engine
    typedef struct packed {
        logic busy;
        logic done;
    } eng_status_t;

    // Word indices of the register map, gaps read as zero
    typedef enum logic [`EX_CSR_ADDR_W-1:0] {
        CSR_ID_LO       = 4'd0,
        CSR_ID_HI       = 4'd1,
        CSR_CONFIG      = 4'd2,
        CSR_FREQ_CTRL   = 4'd3,
        CSR_FREQ_RESULT = 4'd4,
        CSR_RD_BASE     = 4'd8,
        CSR_RD_COUNT    = 4'd9,
        CSR_RD_CTRL     = 4'd10,
        CSR_RD_SUM      = 4'd11,
        CSR_WR_BASE     = 4'd12,
        CSR_WR_COUNT    = 4'd13,
        CSR_WR_PATTERN  = 4'd14,
        CSR_WR_CTRL     = 4'd15
    } csr_index_e;

endpackage

//--- source/engine_csr_if.sv
`timescale 1ns/1ps

// Control path between the register block and a single engine
interface engine_csr_if;
    import exerciser_pkg::*;

    // Run parameters, held steady by the manager
    eng_cmd_t    cmd;
    // One-cycle start strobe
    logic        start;
    // Busy and sticky done reported back by the engine
    eng_status_t status;
    // Engine specific result word (checksum, cycle count, frequency)
    logic [63:0] result;

    // The register block side
    modport manager
    (
        output cmd,
        output start,
        input  status,
        input  result
    );

    // The datapath side
    modport engine
    (
        input  cmd,
        input  start,
        output status,
        output result
    );

endinterface

//--- source/csr_mgr.sv
`timescale 1ns/1ps
`include "exerciser_cfg.svh"

module csr_mgr
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      csr_wr,
    input  logic                      csr_rd,
    input  logic [`EX_CSR_ADDR_W-1:0] csr_addr,
    input  logic [63:0]               csr_wdata,
    output logic                      csr_rd_valid,
    output logic [63:0]               csr_rdata,
    engine_csr_if.manager             rd_csr,
    engine_csr_if.manager             wr_csr,
    engine_csr_if.manager             freq_csr
);
    import exerciser_pkg::*;

    localparam int ADDR_W  = `EX_ADDR_W;
    localparam int COUNT_W = `EX_COUNT_W;

    csr_index_e         idx;
    logic [ADDR_W-1:0]  rd_base;
    logic [COUNT_W-1:0] rd_lines;
    logic [ADDR_W-1:0]  wr_base;
    logic [COUNT_W-1:0] wr_lines;
    logic [63:0]        wr_pattern;
    logic               rd_start;
    logic               wr_start;
    logic               freq_start;
    logic [63:0]        rd_mux;

    // Register accesses and reads share the same word index
    assign idx = csr_index_e'(csr_addr);

    // ========================================
    // Command registers and start strobes
    // ========================================

    // A start is dropped while the engine is busy or a start is already on its way
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_base    <= '0;
            rd_lines   <= '0;
            wr_base    <= '0;
            wr_lines   <= '0;
            wr_pattern <= '0;
            rd_start   <= 1'b0;
            wr_start   <= 1'b0;
            freq_start <= 1'b0;
        end
        else
        begin
            rd_start   <= 1'b0;
            wr_start   <= 1'b0;
            freq_start <= 1'b0;
            if (csr_wr)
            begin
                case (idx)
                    CSR_FREQ_CTRL:
                        freq_start <= csr_wdata[0] && !freq_csr.status.busy && !freq_start;
                    CSR_RD_BASE:    rd_base    <= csr_wdata[ADDR_W-1:0];
                    CSR_RD_COUNT:   rd_lines   <= csr_wdata[COUNT_W-1:0];
                    CSR_RD_CTRL:
                        rd_start <= csr_wdata[0] && !rd_csr.status.busy && !rd_start;
                    CSR_WR_BASE:    wr_base    <= csr_wdata[ADDR_W-1:0];
                    CSR_WR_COUNT:   wr_lines   <= csr_wdata[COUNT_W-1:0];
                    CSR_WR_PATTERN: wr_pattern <= csr_wdata;
                    CSR_WR_CTRL:
                        wr_start <= csr_wdata[0] && !wr_csr.status.busy && !wr_start;
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    assign rd_csr.start   = rd_start;
    assign wr_csr.start   = wr_start;
    assign freq_csr.start = freq_start;

    // The read engine has no use for a pattern
    assign rd_csr.cmd = '{base_addr: rd_base, num_lines: rd_lines, pattern: '0};
    assign wr_csr.cmd = '{base_addr: wr_base, num_lines: wr_lines, pattern: wr_pattern};
    // The frequency counter reacts to the start strobe only
    assign freq_csr.cmd = '0;

    // ========================================
    // Read data
    // ========================================

    always_comb
    begin
        rd_mux = '0;
        case (idx)
            CSR_ID_LO:       rd_mux = `EX_TEST_ID_LO;
            CSR_ID_HI:       rd_mux = `EX_TEST_ID_HI;
            // Engine count in byte 0, read outstanding limit in byte 1
            CSR_CONFIG:
                rd_mux = 64'({8'(`EX_RD_MAX_OUTSTANDING), 8'(`EX_NUM_ENGINES)});
            CSR_FREQ_CTRL:   rd_mux = 64'(freq_csr.status);
            CSR_FREQ_RESULT: rd_mux = freq_csr.result;
            CSR_RD_BASE:     rd_mux = 64'(rd_base);
            CSR_RD_COUNT:    rd_mux = 64'(rd_lines);
            CSR_RD_CTRL:     rd_mux = 64'(rd_csr.status);
            CSR_RD_SUM:      rd_mux = rd_csr.result;
            CSR_WR_BASE:     rd_mux = 64'(wr_base);
            CSR_WR_COUNT:    rd_mux = 64'(wr_lines);
            CSR_WR_PATTERN:  rd_mux = wr_pattern;
            // Status in the low bits, the run cycle count in the upper half
            CSR_WR_CTRL:     rd_mux = {wr_csr.result[31:0], 30'd0, wr_csr.status};
            default:         rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            csr_rd_valid <= 1'b0;
        end
        else
        begin
            csr_rd_valid <= csr_rd;
        end
    end

    always_ff @(posedge clk)
    begin
        if (csr_rd)
        begin
            csr_rdata <= rd_mux;
        end
    end

endmodule

//--- source/rd_engine.sv
`timescale 1ns/1ps
`include "exerciser_cfg.svh"

module rd_engine
(
    input  logic                  clk,
    input  logic                  rst_n,
    engine_csr_if.engine          csrs,
    output logic                  mem_rd_req,
    output logic [`EX_ADDR_W-1:0] mem_rd_addr,
    input  logic                  mem_rd_rsp_valid,
    input  logic [63:0]           mem_rd_rsp_data
);
    localparam int ADDR_W  = `EX_ADDR_W;
    localparam int COUNT_W = `EX_COUNT_W;

    logic               busy_q;
    logic               done_q;
    logic [COUNT_W-1:0] issue_cnt;
    logic [COUNT_W-1:0] rsp_cnt;
    logic [COUNT_W-1:0] in_flight;
    logic [63:0]        sum_q;
    logic [ADDR_W-1:0]  base_q;
    logic [COUNT_W-1:0] lines_q;
    logic               last_rsp;

    // Responses come back in order, so the gap between the counters is the in-flight count
    assign in_flight = issue_cnt - rsp_cnt;
    assign last_rsp  = mem_rd_rsp_valid && (rsp_cnt == lines_q - COUNT_W'(1));

    // Keep issuing while lines remain and the outstanding limit allows it
    assign mem_rd_req  = busy_q && (issue_cnt != lines_q) &&
                         (in_flight < COUNT_W'(`EX_RD_MAX_OUTSTANDING));
    assign mem_rd_addr = base_q + ADDR_W'(issue_cnt);

    // Run parameters are captured at start so the host may reprogram mid-run
    always_ff @(posedge clk)
    begin
        if (csrs.start)
        begin
            base_q  <= csrs.cmd.base_addr;
            lines_q <= csrs.cmd.num_lines;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            issue_cnt <= '0;
            rsp_cnt   <= '0;
            sum_q     <= '0;
        end
        else if (csrs.start)
        begin
            issue_cnt <= '0;
            rsp_cnt   <= '0;
            sum_q     <= '0;
            // An empty run is over before it starts
            busy_q    <= (csrs.cmd.num_lines != '0);
            done_q    <= (csrs.cmd.num_lines == '0);
        end
        else if (busy_q)
        begin
            if (mem_rd_req)
            begin
                issue_cnt <= issue_cnt + COUNT_W'(1);
            end
            if (mem_rd_rsp_valid)
            begin
                rsp_cnt <= rsp_cnt + COUNT_W'(1);
                sum_q   <= sum_q + mem_rd_rsp_data;
            end
            if (last_rsp)
            begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    assign csrs.status = {busy_q, done_q};
    assign csrs.result = sum_q;

endmodule

//--- source/wr_engine.sv
`timescale 1ns/1ps
`include "exerciser_cfg.svh"

module wr_engine
(
    input  logic                  clk,
    input  logic                  rst_n,
    engine_csr_if.engine          csrs,
    output logic                  mem_wr_req,
    output logic [`EX_ADDR_W-1:0] mem_wr_addr,
    output logic [63:0]           mem_wr_data
);
    localparam int ADDR_W  = `EX_ADDR_W;
    localparam int COUNT_W = `EX_COUNT_W;

    logic               busy_q;
    logic               done_q;
    logic [COUNT_W-1:0] cycle_cnt;
    logic [ADDR_W-1:0]  addr_q;
    logic [63:0]        pattern_q;
    logic [COUNT_W-1:0] lines_q;

    // Memory takes a write every cycle, so a write goes out in every busy cycle
    assign mem_wr_req  = busy_q;
    assign mem_wr_addr = addr_q;
    assign mem_wr_data = 64'(addr_q) ^ pattern_q;

    // Address steps by one line per write starting from the base
    always_ff @(posedge clk)
    begin
        if (csrs.start)
        begin
            addr_q    <= csrs.cmd.base_addr;
            pattern_q <= csrs.cmd.pattern;
            lines_q   <= csrs.cmd.num_lines;
        end
        else if (busy_q)
        begin
            addr_q <= addr_q + ADDR_W'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            cycle_cnt <= '0;
        end
        else if (csrs.start)
        begin
            cycle_cnt <= '0;
            busy_q    <= (csrs.cmd.num_lines != '0);
            done_q    <= (csrs.cmd.num_lines == '0);
        end
        else if (busy_q)
        begin
            cycle_cnt <= cycle_cnt + COUNT_W'(1);
            // The cycle that carries the last write closes the run
            if (cycle_cnt == lines_q - COUNT_W'(1))
            begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    assign csrs.status = {busy_q, done_q};
    assign csrs.result = 64'(cycle_cnt);

endmodule

//--- source/clk_freq_counter.sv
`timescale 1ns/1ps
`include "exerciser_cfg.svh"

module clk_freq_counter
(
    input  logic         clk,
    input  logic         pclk,
    input  logic         rst_n,
    engine_csr_if.engine csrs
);
    localparam int WIN_W = $clog2(`EX_FREQ_WINDOW);

    logic             start_tgl;
    logic [2:0]       tgl_sync;
    logic             win_en;
    logic [WIN_W-1:0] win_cnt;
    logic [2:0]       en_sync;
    logic             busy_q;
    logic             done_q;
    logic [31:0]      freq_cnt;

    // ========================================
    // pclk domain measurement window
    // ========================================

    // The start pulse crosses as a level change and is detected as an edge here
    always_ff @(posedge pclk)
    begin
        if (!rst_n)
        begin
            tgl_sync <= '0;
            win_en   <= 1'b0;
            win_cnt  <= '0;
        end
        else
        begin
            tgl_sync <= {tgl_sync[1:0], start_tgl};
            if (tgl_sync[2] != tgl_sync[1])
            begin
                win_en  <= 1'b1;
                win_cnt <= '0;
            end
            else if (win_en)
            begin
                win_cnt <= win_cnt + WIN_W'(1);
                if (win_cnt == WIN_W'(`EX_FREQ_WINDOW - 1))
                begin
                    win_en <= 1'b0;
                end
            end
        end
    end

    // ========================================
    // clk domain counting
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            start_tgl <= 1'b0;
            en_sync   <= '0;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            freq_cnt  <= '0;
        end
        else
        begin
            // Bits 1:0 form the synchronizer, bit 2 only serves the falling edge check
            en_sync <= {en_sync[1:0], win_en};
            if (csrs.start)
            begin
                start_tgl <= ~start_tgl;
                busy_q    <= 1'b1;
                done_q    <= 1'b0;
                freq_cnt  <= '0;
            end
            else if (busy_q)
            begin
                if (en_sync[1])
                begin
                    freq_cnt <= freq_cnt + 32'd1;
                end
                // Window closed once the synchronized enable falls
                if (en_sync[2] && !en_sync[1])
                begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    assign csrs.status = {busy_q, done_q};
    assign csrs.result = 64'(freq_cnt);

endmodule

//--- source/mem_exerciser_top.sv
`timescale 1ns/1ps
`include "exerciser_cfg.svh"

module mem_exerciser_top
(
    input  logic                      clk,
    // Known reference used to measure the frequency of clk
    input  logic                      pclk,
    input  logic                      rst_n,

    input  logic                      csr_wr,
    input  logic                      csr_rd,
    input  logic [`EX_CSR_ADDR_W-1:0] csr_addr,
    input  logic [63:0]               csr_wdata,
    output logic                      csr_rd_valid,
    output logic [63:0]               csr_rdata,

    output logic                      mem_rd_req,
    output logic [`EX_ADDR_W-1:0]     mem_rd_addr,
    input  logic                      mem_rd_rsp_valid,
    input  logic [63:0]               mem_rd_rsp_data,

    output logic                      mem_wr_req,
    output logic [`EX_ADDR_W-1:0]     mem_wr_addr,
    output logic [63:0]               mem_wr_data
);

    // One control channel per engine
    engine_csr_if rd_csr();
    engine_csr_if wr_csr();
    engine_csr_if freq_csr();

    // ========================================
    // Register block
    // ========================================

    csr_mgr csr_mgr
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_wr       (csr_wr),
        .csr_rd       (csr_rd),
        .csr_addr     (csr_addr),
        .csr_wdata    (csr_wdata),
        .csr_rd_valid (csr_rd_valid),
        .csr_rdata    (csr_rdata),
        .rd_csr       (rd_csr),
        .wr_csr       (wr_csr),
        .freq_csr     (freq_csr)
    );

    // ========================================
    // Engines
    // ========================================

    rd_engine rd_eng
    (
        .clk              (clk),
        .rst_n            (rst_n),
        .csrs             (rd_csr),
        .mem_rd_req       (mem_rd_req),
        .mem_rd_addr      (mem_rd_addr),
        .mem_rd_rsp_valid (mem_rd_rsp_valid),
        .mem_rd_rsp_data  (mem_rd_rsp_data)
    );

    wr_engine wr_eng
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .csrs        (wr_csr),
        .mem_wr_req  (mem_wr_req),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data)
    );

    clk_freq_counter freq_cnt
    (
        .clk   (clk),
        .pclk  (pclk),
        .rst_n (rst_n),
        .csrs  (freq_csr)
    );

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic clk,
    output logic pclk,
    output logic rst_n
);

    // The design clock runs at twice the reference rate
    always #50 clk = ~clk;
    always #100 pclk = ~pclk;

    // Reset covers three rising edges and lifts on a falling edge
    initial
    begin
        clk   = 1'b0;
        pclk  = 1'b0;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- test/host_mem_model.sv
`timescale 1ns/1ps

module host_mem_model
#(
    parameter logic [31:0] SEED  = 32'h1,
    parameter int          LINES = 64
)
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_rd_req,
    input  logic [31:0] mem_rd_addr,
    output logic        mem_rd_rsp_valid,
    output logic [63:0] mem_rd_rsp_data,
    input  logic        mem_wr_req,
    input  logic [31:0] mem_wr_addr,
    input  logic [63:0] mem_wr_data
);

    // Read contents, indexed by the low address bits
    logic [63:0] rd_data [0:LINES-1];
    // Every read request address is kept in issue order
    logic [31:0] rd_addr_log [0:LINES-1];
    // Every accepted write lands here for the testbench to inspect
    logic [31:0] wr_addr_log [0:LINES-1];
    logic [63:0] wr_data_log [0:LINES-1];
    int          rd_count;
    int          wr_count;
    int          cycle;
    int          last_due;
    int          due;
    int          due_q [$];
    logic [31:0] addr_q [$];
    logic [31:0] state;
    logic [31:0] hi_word;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Each line takes two draws, upper word first
    initial
    begin
        state = SEED;
        for (int i = 0; i < LINES; i++)
        begin
            state      = lcg_next(state);
            hi_word    = state;
            state      = lcg_next(state);
            rd_data[i] = {hi_word, state};
        end
        mem_rd_rsp_valid = 1'b0;
        mem_rd_rsp_data  = '0;
        rd_count         = 0;
        wr_count         = 0;
        cycle            = 0;
        last_due         = 0;
    end

    // ========================================
    // Request capture and in-order responses
    // ========================================

    // Everything happens on the falling edge, where the DUT outputs are settled
    always @(negedge clk)
    begin
        cycle = cycle + 1;
        if (!rst_n)
        begin
            mem_rd_rsp_valid <= 1'b0;
        end
        else
        begin
            if (mem_rd_req)
            begin
                // Latency of 1 to 6 cycles, pushed back when it would overtake an older read
                state = lcg_next(state);
                due   = cycle + 1 + int'(state[23:16] % 8'd6);
                if (due <= last_due)
                begin
                    due = last_due + 1;
                end
                last_due = due;
                due_q.push_back(due);
                addr_q.push_back(mem_rd_addr);
                if (rd_count < LINES)
                begin
                    rd_addr_log[rd_count] = mem_rd_addr;
                end
                rd_count = rd_count + 1;
            end
            if (due_q.size() > 0 && due_q[0] == cycle)
            begin
                mem_rd_rsp_valid <= 1'b1;
                mem_rd_rsp_data  <= rd_data[addr_q[0] % LINES];
                void'(due_q.pop_front());
                void'(addr_q.pop_front());
            end
            else
            begin
                mem_rd_rsp_valid <= 1'b0;
            end
            if (mem_wr_req)
            begin
                if (wr_count < LINES)
                begin
                    wr_addr_log[wr_count] = mem_wr_addr;
                    wr_data_log[wr_count] = mem_wr_data;
                end
                wr_count = wr_count + 1;
            end
        end
    end

endmodule

//--- test/mem_exerciser_properties.sv
`timescale 1ns/1ps
`include "exerciser_cfg.svh"

module mem_exerciser_properties
(
    input logic clk,
    input logic rst_n,
    input logic csr_rd,
    input logic csr_rd_valid,
    input logic mem_rd_req,
    input logic mem_rd_rsp_valid,
    input logic mem_wr_req
);

    // Reads issued but not yet answered, as seen on the ports
    logic [7:0] reads_open;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            reads_open <= '0;
        end
        else
        begin
            reads_open <= reads_open + 8'(mem_rd_req) - 8'(mem_rd_rsp_valid);
        end
    end

    rd_valid_follows_rd: assert property (@(posedge clk) disable iff (!rst_n)
        csr_rd_valid == $past(csr_rd))
        else $error("csr_rd_valid does not follow csr_rd by one cycle");

    // Engines stay quiet right after reset
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!mem_rd_req && !mem_wr_req) [*3])
        else $error("memory request within three cycles of reset");

    outstanding_limit: assert property (@(posedge clk) disable iff (!rst_n)
        reads_open <= 8'(`EX_RD_MAX_OUTSTANDING))
        else $error("too many reads in flight");

endmodule

bind mem_exerciser_top mem_exerciser_properties props (.*);

//--- test/tb_mem_exerciser.sv
`timescale 1ns/1ps
`include "exerciser_cfg.svh"

module tb_mem_exerciser;
    import exerciser_pkg::*;

    localparam logic [31:0] SEED       = 32'h8bef_de3a;
    localparam int          MEM_LINES  = 64;
    localparam logic [31:0] WR_BASE    = 32'h100;
    localparam int          WR_LINES   = 20;
    localparam logic [63:0] WR_PATTERN = 64'hc3a5_0f1e_9b27_d460;
    localparam logic [31:0] RD_BASE    = 32'h208;
    localparam int          RD_LINES   = 32;

    // Kinds of table row
    typedef enum logic [2:0]
    {
        OP_WRITE,
        OP_CHECK,
        OP_NEAR,
        OP_WAIT,
        OP_READS,
        OP_WRITES
    } op_e;

    // For OP_NEAR the data field is the tolerance, for OP_WAIT the poll limit
    typedef struct packed
    {
        op_e         op;
        logic [3:0]  addr;
        logic [63:0] data;
        logic [63:0] exp_val;
    } step_t;

    logic        clk;
    logic        pclk;
    logic        rst_n;
    logic        csr_wr;
    logic        csr_rd;
    logic [3:0]  csr_addr;
    logic [63:0] csr_wdata;
    logic        csr_rd_valid;
    logic [63:0] csr_rdata;
    logic        mem_rd_req;
    logic [31:0] mem_rd_addr;
    logic        mem_rd_rsp_valid;
    logic [63:0] mem_rd_rsp_data;
    logic        mem_wr_req;
    logic [31:0] mem_wr_addr;
    logic [63:0] mem_wr_data;

    step_t       steps [0:39];
    int          num_steps;
    logic [63:0] line_data [0:MEM_LINES-1];
    logic [63:0] rd_sum;
    logic [31:0] state;
    logic [31:0] hi_word;
    int          waited;

    tb_clk_gen clk_gen
    (
        .clk   (clk),
        .pclk  (pclk),
        .rst_n (rst_n)
    );

    mem_exerciser_top DUT
    (
        .clk              (clk),
        .pclk             (pclk),
        .rst_n            (rst_n),
        .csr_wr           (csr_wr),
        .csr_rd           (csr_rd),
        .csr_addr         (csr_addr),
        .csr_wdata        (csr_wdata),
        .csr_rd_valid     (csr_rd_valid),
        .csr_rdata        (csr_rdata),
        .mem_rd_req       (mem_rd_req),
        .mem_rd_addr      (mem_rd_addr),
        .mem_rd_rsp_valid (mem_rd_rsp_valid),
        .mem_rd_rsp_data  (mem_rd_rsp_data),
        .mem_wr_req       (mem_wr_req),
        .mem_wr_addr      (mem_wr_addr),
        .mem_wr_data      (mem_wr_data)
    );

    host_mem_model #(.SEED(SEED), .LINES(MEM_LINES)) mem
    (
        .clk              (clk),
        .rst_n            (rst_n),
        .mem_rd_req       (mem_rd_req),
        .mem_rd_addr      (mem_rd_addr),
        .mem_rd_rsp_valid (mem_rd_rsp_valid),
        .mem_rd_rsp_data  (mem_rd_rsp_data),
        .mem_wr_req       (mem_wr_req),
        .mem_wr_addr      (mem_wr_addr),
        .mem_wr_data      (mem_wr_data)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ========================================
    // Failure reporting
    // ========================================

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // ========================================
    // Register access
    // ========================================

    // All register tasks start and end on a falling edge
    task automatic csr_write(input logic [3:0] addr, input logic [63:0] data);
        csr_addr  = addr;
        csr_wdata = data;
        csr_wr    = 1'b1;
        @(negedge clk);
        csr_wr    = 1'b0;
    endtask

    task automatic csr_read(input logic [3:0] addr, output logic [63:0] data);
        int n;
        n        = 0;
        csr_addr = addr;
        csr_rd   = 1'b1;
        @(negedge clk);
        csr_rd   = 1'b0;
        while (!csr_rd_valid && n < 4)
        begin
            @(negedge clk);
            n++;
        end
        if (!csr_rd_valid)
        begin
            report_timeout($sformatf("read data from register word %0d", addr));
        end
        data = csr_rdata;
    endtask

    // Done is bit 0 of every status word
    task automatic wait_done(input logic [3:0] addr, input int max_polls);
        logic [63:0] status;
        int polls;
        polls = 0;
        csr_read(addr, status);
        while (!status[0] && polls < max_polls)
        begin
            polls++;
            csr_read(addr, status);
        end
        if (!status[0])
        begin
            report_timeout($sformatf("done on register word %0d", addr));
        end
    endtask

    // Writes must run upward from the base, each carrying its address XOR the pattern
    task automatic check_write_log(input int lines);
        logic [31:0] exp_addr;
        assert (mem.wr_count == lines)
            else report_error($sformatf("%0d writes seen, expected %0d", mem.wr_count, lines));
        for (int i = 0; i < lines; i++)
        begin
            exp_addr = WR_BASE + 32'(i);
            assert (mem.wr_addr_log[i] == exp_addr)
                else report_error($sformatf("write %0d to %h, expected %h",
                    i, mem.wr_addr_log[i], exp_addr));
            assert (mem.wr_data_log[i] == ({32'd0, exp_addr} ^ WR_PATTERN))
                else report_error($sformatf("write %0d carried %h", i, mem.wr_data_log[i]));
        end
    endtask

    // Reads must also run upward from the base, one request per line
    task automatic check_read_log(input int lines);
        logic [31:0] exp_addr;
        assert (mem.rd_count == lines)
            else report_error($sformatf("%0d reads seen, expected %0d", mem.rd_count, lines));
        for (int i = 0; i < lines; i++)
        begin
            exp_addr = RD_BASE + 32'(i);
            assert (mem.rd_addr_log[i] == exp_addr)
                else report_error($sformatf("read %0d from %h, expected %h",
                    i, mem.rd_addr_log[i], exp_addr));
        end
    endtask

    task automatic run_step(input step_t s);
        logic [63:0] got;
        case (s.op)
            OP_WRITE:
                csr_write(s.addr, s.data);
            OP_CHECK:
            begin
                csr_read(s.addr, got);
                assert (got == s.exp_val)
                    else report_error($sformatf("word %0d read %h, expected %h",
                        s.addr, got, s.exp_val));
            end
            OP_NEAR:
            begin
                csr_read(s.addr, got);
                assert (got + s.data >= s.exp_val && got <= s.exp_val + s.data)
                    else report_error($sformatf("word %0d read %0d, expected %0d +/- %0d",
                        s.addr, got, s.exp_val, s.data));
            end
            OP_WAIT:
                wait_done(s.addr, int'(s.data));
            OP_READS:
                check_read_log(int'(s.exp_val));
            default:
                check_write_log(int'(s.exp_val));
        endcase
    endtask

    task automatic add_step(input op_e op, input logic [3:0] addr,
                            input logic [63:0] data, input logic [63:0] exp_val);
        steps[num_steps].op      = op;
        steps[num_steps].addr    = addr;
        steps[num_steps].data    = data;
        steps[num_steps].exp_val = exp_val;
        num_steps++;
    endtask

    // ========================================
    // Stimulus table and run
    // ========================================

    initial
    begin
        csr_wr    = 1'b0;
        csr_rd    = 1'b0;
        csr_addr  = '0;
        csr_wdata = '0;
        num_steps = 0;

        // Same draws as the memory preload, so the checksum is known up front
        state = SEED;
        for (int i = 0; i < MEM_LINES; i++)
        begin
            state        = next_random(state);
            hi_word      = state;
            state        = next_random(state);
            line_data[i] = {hi_word, state};
        end
        rd_sum = '0;
        for (int i = 0; i < RD_LINES; i++)
        begin
            rd_sum = rd_sum + line_data[(RD_BASE + i) % MEM_LINES];
        end

        // Idle status, identity, config and unmapped words
        add_step(OP_CHECK, CSR_FREQ_CTRL, 0, 0);
        add_step(OP_CHECK, CSR_RD_CTRL, 0, 0);
        add_step(OP_CHECK, CSR_WR_CTRL, 0, 0);
        add_step(OP_CHECK, CSR_ID_LO, 0, `EX_TEST_ID_LO);
        add_step(OP_CHECK, CSR_ID_HI, 0, `EX_TEST_ID_HI);
        add_step(OP_CHECK, CSR_CONFIG, 0, {48'd0, 8'(`EX_RD_MAX_OUTSTANDING), 8'd3});
        add_step(OP_CHECK, 4'd5, 0, 0);
        add_step(OP_CHECK, 4'd7, 0, 0);
        // Write run, result sits in the upper half of the control word
        add_step(OP_WRITE, CSR_WR_BASE, WR_BASE, 0);
        add_step(OP_WRITE, CSR_WR_COUNT, WR_LINES, 0);
        add_step(OP_WRITE, CSR_WR_PATTERN, WR_PATTERN, 0);
        add_step(OP_WRITE, CSR_WR_CTRL, 1, 0);
        add_step(OP_WAIT, CSR_WR_CTRL, 200, 0);
        add_step(OP_CHECK, CSR_WR_CTRL, 0, {32'(WR_LINES), 32'd1});
        add_step(OP_WRITES, 0, 0, WR_LINES);
        // Read run with a second start landing while busy
        add_step(OP_WRITE, CSR_RD_BASE, RD_BASE, 0);
        add_step(OP_WRITE, CSR_RD_COUNT, RD_LINES, 0);
        add_step(OP_WRITE, CSR_RD_CTRL, 1, 0);
        // Busy shows two cycles after the start write, the base readback covers the gap
        add_step(OP_CHECK, CSR_RD_BASE, 0, RD_BASE);
        add_step(OP_CHECK, CSR_RD_CTRL, 0, 64'd2);
        add_step(OP_WRITE, CSR_RD_CTRL, 1, 0);
        add_step(OP_WAIT, CSR_RD_CTRL, 500, 0);
        add_step(OP_CHECK, CSR_RD_CTRL, 0, 64'd1);
        add_step(OP_CHECK, CSR_RD_SUM, 0, rd_sum);
        add_step(OP_READS, 0, 0, RD_LINES);
        // Empty read run issues nothing and clears the checksum
        add_step(OP_WRITE, CSR_RD_COUNT, 0, 0);
        add_step(OP_WRITE, CSR_RD_CTRL, 1, 0);
        add_step(OP_WAIT, CSR_RD_CTRL, 20, 0);
        add_step(OP_CHECK, CSR_RD_CTRL, 0, 64'd1);
        add_step(OP_CHECK, CSR_RD_SUM, 0, 0);
        add_step(OP_READS, 0, 0, RD_LINES);
        // clk is twice pclk, so one window should hold about twice its length
        add_step(OP_WRITE, CSR_FREQ_CTRL, 1, 0);
        add_step(OP_WAIT, CSR_FREQ_CTRL, 2000, 0);
        add_step(OP_NEAR, CSR_FREQ_RESULT, 2, 2 * `EX_FREQ_WINDOW);

        waited = 0;
        while (!rst_n && waited < 10)
        begin
            @(posedge clk);
            waited++;
        end
        if (!rst_n)
        begin
            report_timeout("reset release");
        end
        @(negedge clk);

        assert (!csr_rd_valid && !mem_rd_req && !mem_wr_req)
            else report_error("outputs not idle after reset");

        for (int i = 0; i < num_steps; i++)
        begin
            run_step(steps[i]);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- files.f
+incdir+include
source/exerciser_pkg.sv
source/engine_csr_if.sv
source/csr_mgr.sv
source/rd_engine.sv
source/wr_engine.sv
source/clk_freq_counter.sv
source/mem_exerciser_top.sv
test/tb_clk_gen.sv
test/host_mem_model.sv
test/mem_exerciser_properties.sv
test/tb_mem_exerciser.sv
